/* compile.f */
design/pkt_sched_pkg.sv
design/sync_fifo.sv
design/ctrl_regs.sv
design/slot_tracker.sv
design/rx_dispatch.sv
design/msg_arbiter.sv
design/tx_dispatch.sv
design/pkt_sched_top.sv
verification/pkt_sched_props.sv
verification/tb_pkt_sched.sv

/* design/ctrl_regs.sv */
module ctrl_regs
  import pkt_sched_pkg::*;
(
  input  logic                         logic_clk,
  input  logic                         rst_n,
  input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                         s_axil_awvalid,
  output logic                         s_axil_awready,
  input  logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                         s_axil_wvalid,
  output logic                         s_axil_wready,
  output logic [1:0]                   s_axil_bresp,
  output logic                         s_axil_bvalid,
  input  logic                         s_axil_bready,
  input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                         s_axil_arvalid,
  output logic                         s_axil_arready,
  output logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
  output logic [1:0]                   s_axil_rresp,
  output logic                         s_axil_rvalid,
  input  logic                         s_axil_rready,
  output logic                         enable,
  output slot_addr_t [SLOT_COUNT-1:0]  slot_addr,
  output logic [SLOT_COUNT-1:0]        slot_valid
);

  logic     wr_accept;
  logic     rd_accept;
  logic     wr_slot_hit;
  logic     rd_slot_hit;
  slot_id_t wr_slot;
  slot_id_t rd_slot;

  function automatic logic is_slot_reg(input logic [AXIL_ADDR_WIDTH-1:0] addr);
    return (addr[1:0] == 2'b00) && (addr >= REG_SLOT_BASE) &&
           (addr < REG_SLOT_BASE + 4 * SLOT_COUNT);
  endfunction

  function automatic slot_id_t slot_index(input logic [AXIL_ADDR_WIDTH-1:0] addr);
    return slot_id_t'((addr - REG_SLOT_BASE) >> 2);
  endfunction

  // address and data taken together, one write in flight
  assign wr_accept      = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
  assign s_axil_awready = wr_accept;
  assign s_axil_wready  = wr_accept;
  assign wr_slot_hit    = is_slot_reg(s_axil_awaddr);
  assign wr_slot        = slot_index(s_axil_awaddr);

  assign s_axil_arready = !s_axil_rvalid;
  assign rd_accept      = s_axil_arvalid && s_axil_arready;
  assign rd_slot_hit    = is_slot_reg(s_axil_araddr);
  assign rd_slot        = slot_index(s_axil_araddr);

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      s_axil_bvalid <= 1'b0;
      s_axil_rvalid <= 1'b0;
      enable        <= 1'b0;
      slot_valid    <= '0;
    end else begin
      if (wr_accept) begin
        s_axil_bvalid <= 1'b1;
      end else if (s_axil_bready) begin
        s_axil_bvalid <= 1'b0;
      end
      if (rd_accept) begin
        s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
        s_axil_rvalid <= 1'b0;
      end
      // control bit and slot addresses all sit in byte 0
      if (wr_accept && s_axil_wstrb[0]) begin
        if (s_axil_awaddr == REG_CTRL) begin
          enable <= s_axil_wdata[0];
        end else if (wr_slot_hit) begin
          slot_valid[wr_slot] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (wr_accept) begin
      s_axil_bresp <= (s_axil_awaddr == REG_CTRL || wr_slot_hit) ?
                      AXI_RESP_OKAY : AXI_RESP_SLVERR;
      if (wr_slot_hit && s_axil_wstrb[0]) begin
        slot_addr[wr_slot] <= s_axil_wdata[SLOT_ADDR_EFF-1:0];
      end
    end
    if (rd_accept) begin
      if (s_axil_araddr == REG_CTRL) begin
        s_axil_rdata <= AXIL_DATA_WIDTH'(enable);
        s_axil_rresp <= AXI_RESP_OKAY;
      end else if (rd_slot_hit) begin
        s_axil_rdata <= AXIL_DATA_WIDTH'(slot_addr[rd_slot]);
        s_axil_rresp <= AXI_RESP_OKAY;
      end else begin
        s_axil_rdata <= '0;
        s_axil_rresp <= AXI_RESP_SLVERR;
      end
    end
  end

endmodule

/* design/msg_arbiter.sv */
module msg_arbiter
  import pkt_sched_pkg::*;
(
  input  logic                   logic_clk,
  input  logic                   rst_n,
  input  msg_t [CORE_COUNT-1:0]  core_msg_data,
  input  logic [CORE_COUNT-1:0]  core_msg_valid,
  output msg_t                   msg_data,
  output core_id_t               msg_core_no,
  output logic                   msg_valid,
  input  logic                   msg_ready
);

  msg_t [CORE_COUNT-1:0] head;
  logic [CORE_COUNT-1:0] empty;
  logic [CORE_COUNT-1:0] pop;
  core_id_t              rr_next;
  logic                  grant;

  for (genvar i = 0; i < CORE_COUNT; i++) begin : g_core_fifo
    // no full flag back to the core, senders pace themselves
    sync_fifo #(
      .payload_t (msg_t),
      .ADDR_SIZE (FIFO_ADDR_SIZE)
    ) u_fifo (
      .logic_clk (logic_clk),
      .rst_n     (rst_n),
      .wr_data   (core_msg_data[i]),
      .wr_en     (core_msg_valid[i]),
      .full      (),
      .rd_data   (head[i]),
      .rd_en     (pop[i]),
      .empty     (empty[i])
    );

    assign pop[i] = grant && (msg_core_no == core_id_t'(i));
  end

  assign msg_valid   = !(&empty);
  assign msg_core_no = rr_pick(~empty, rr_next);
  assign msg_data    = head[msg_core_no];
  assign grant       = msg_valid && msg_ready;

  // search restarts after the core just served
  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      rr_next <= '0;
    end else if (grant) begin
      rr_next <= msg_core_no + 1'b1;
    end
  end

endmodule

/* design/pkt_sched_pkg.sv */
package pkt_sched_pkg;

  // system sizes
  localparam int CORE_COUNT      = 4;
  localparam int SLOT_COUNT      = 4;
  localparam int CORE_BITS       = $clog2(CORE_COUNT);
  localparam int SLOT_BITS       = $clog2(SLOT_COUNT);
  localparam int SLOT_TOTAL      = CORE_COUNT * SLOT_COUNT;
  localparam int CORE_ADDR_WIDTH = 16;
  localparam int ADDR_WIDTH      = CORE_ADDR_WIDTH + CORE_BITS;
  localparam int SLOT_LEAD_ZERO  = 8;
  localparam int SLOT_ADDR_EFF   = CORE_ADDR_WIDTH - 1 - SLOT_LEAD_ZERO;
  localparam logic [7:0] RX_WRITE_OFFSET = 8'h0A;
  localparam int LEN_WIDTH       = 16;
  localparam int FIFO_ADDR_SIZE  = 2;

  // core message layout
  localparam int MSG_WIDTH    = 64;
  localparam int MSG_LEN_LSB  = 0;
  localparam int MSG_SLOT_LSB = 16;

  // register block
  localparam int AXIL_DATA_WIDTH       = 32;
  localparam int AXIL_ADDR_WIDTH       = 8;
  localparam logic [7:0] REG_CTRL      = 8'h00;
  localparam logic [7:0] REG_SLOT_BASE = 8'h10;
  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

  typedef logic [CORE_BITS-1:0]     core_id_t;
  typedef logic [SLOT_BITS-1:0]     slot_id_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [LEN_WIDTH-1:0]     len_t;
  typedef logic [MSG_WIDTH-1:0]     msg_t;
  typedef logic [SLOT_ADDR_EFF-1:0] slot_addr_t;

  typedef struct packed {
    core_id_t core;
    slot_id_t slot;
  } tag_t;

  // core in the top bits, one zero bit, stored slot address, low zeros
  function automatic addr_t slot_base(input core_id_t core, input slot_addr_t saddr);
    return {core, 1'b0, saddr, {SLOT_LEAD_ZERO{1'b0}}};
  endfunction

  // first requesting core at or after start
  function automatic core_id_t rr_pick(input logic [CORE_COUNT-1:0] req,
                                       input core_id_t start);
    core_id_t pick;
    core_id_t cand;
    pick = start;
    for (int i = CORE_COUNT - 1; i >= 0; i--) begin
      cand = core_id_t'(start + i);
      if (req[cand]) begin
        pick = cand;
      end
    end
    return pick;
  endfunction

endpackage

/* design/pkt_sched_top.sv */
module pkt_sched_top
  import pkt_sched_pkg::*;
(
  input  logic                         logic_clk,
  input  logic                         rst_n,
  input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_awaddr,
  input  logic                         s_axil_awvalid,
  output logic                         s_axil_awready,
  input  logic [AXIL_DATA_WIDTH-1:0]   s_axil_wdata,
  input  logic [AXIL_DATA_WIDTH/8-1:0] s_axil_wstrb,
  input  logic                         s_axil_wvalid,
  output logic                         s_axil_wready,
  output logic [1:0]                   s_axil_bresp,
  output logic                         s_axil_bvalid,
  input  logic                         s_axil_bready,
  input  logic [AXIL_ADDR_WIDTH-1:0]   s_axil_araddr,
  input  logic                         s_axil_arvalid,
  output logic                         s_axil_arready,
  output logic [AXIL_DATA_WIDTH-1:0]   s_axil_rdata,
  output logic [1:0]                   s_axil_rresp,
  output logic                         s_axil_rvalid,
  input  logic                         s_axil_rready,
  input  logic                         incoming_pkt_valid,
  input  len_t                         incoming_pkt_len,
  output logic                         incoming_pkt_ready,
  output addr_t                        rx_desc_addr,
  output len_t                         rx_desc_len,
  output tag_t                         rx_desc_tag,
  output logic                         rx_desc_valid,
  input  logic                         rx_desc_ready,
  input  msg_t [CORE_COUNT-1:0]        core_msg_data,
  input  logic [CORE_COUNT-1:0]        core_msg_valid,
  output addr_t                        tx_desc_addr,
  output len_t                         tx_desc_len,
  output tag_t                         tx_desc_tag,
  output logic                         tx_desc_valid,
  input  logic                         tx_desc_ready
);

  logic                        enable;
  slot_addr_t [SLOT_COUNT-1:0] slot_addr;
  logic [SLOT_COUNT-1:0]       slot_valid;
  logic [SLOT_TOTAL-1:0]       avail_mask;

  len_t                        pkt_len;
  logic                        pkt_empty;
  logic                        pkt_full;
  logic                        pkt_rd;

  logic                        alloc_valid;
  core_id_t                    alloc_core;
  slot_id_t                    alloc_slot;
  logic                        release_valid;
  core_id_t                    release_core;
  slot_id_t                    release_slot;

  msg_t                        msg_data;
  core_id_t                    msg_core_no;
  logic                        msg_valid;
  logic                        msg_ready;

  ctrl_regs u_ctrl_regs (.*);

  // incoming lengths wait here until a slot is found
  sync_fifo #(
    .payload_t (len_t),
    .ADDR_SIZE (FIFO_ADDR_SIZE)
  ) u_pkt_fifo (
    .logic_clk (logic_clk),
    .rst_n     (rst_n),
    .wr_data   (incoming_pkt_len),
    .wr_en     (incoming_pkt_valid),
    .full      (pkt_full),
    .rd_data   (pkt_len),
    .rd_en     (pkt_rd),
    .empty     (pkt_empty)
  );

  assign incoming_pkt_ready = !pkt_full;

  slot_tracker u_slot_tracker (.*);

  rx_dispatch u_rx_dispatch (.*);

  msg_arbiter u_msg_arbiter (.*);

  tx_dispatch u_tx_dispatch (.*);

endmodule

/* design/rx_dispatch.sv */
module rx_dispatch
  import pkt_sched_pkg::*;
(
  input  logic                        logic_clk,
  input  logic                        rst_n,
  input  logic                        enable,
  input  slot_addr_t [SLOT_COUNT-1:0] slot_addr,
  input  logic [SLOT_TOTAL-1:0]       avail_mask,
  input  len_t                        pkt_len,
  input  logic                        pkt_empty,
  output logic                        pkt_rd,
  output logic                        alloc_valid,
  output core_id_t                    alloc_core,
  output slot_id_t                    alloc_slot,
  output addr_t                       rx_desc_addr,
  output len_t                        rx_desc_len,
  output tag_t                        rx_desc_tag,
  output logic                        rx_desc_valid,
  input  logic                        rx_desc_ready
);

  logic [CORE_COUNT-1:0] core_avail;
  logic [SLOT_COUNT-1:0] sel_slots;
  core_id_t              rr_next;
  core_id_t              sel_core;
  slot_id_t              sel_slot;
  logic                  take;

  always_comb begin
    for (int c = 0; c < CORE_COUNT; c++) begin
      core_avail[c] = |avail_mask[c*SLOT_COUNT +: SLOT_COUNT];
    end
  end

  assign sel_core  = rr_pick(core_avail, rr_next);
  assign sel_slots = avail_mask[sel_core*SLOT_COUNT +: SLOT_COUNT];

  // lowest free slot wins
  always_comb begin
    sel_slot = '0;
    for (int s = SLOT_COUNT - 1; s >= 0; s--) begin
      if (sel_slots[s]) begin
        sel_slot = slot_id_t'(s);
      end
    end
  end

  assign take        = enable && !pkt_empty && (|core_avail) && !rx_desc_valid;
  assign pkt_rd      = take;
  assign alloc_valid = take;
  assign alloc_core  = sel_core;
  assign alloc_slot  = sel_slot;

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_desc_valid <= 1'b0;
      rr_next       <= '0;
    end else if (take) begin
      rx_desc_valid <= 1'b1;
      rr_next       <= sel_core + 1'b1;
    end else if (rx_desc_ready) begin
      rx_desc_valid <= 1'b0;
    end
  end

  always_ff @(posedge logic_clk) begin
    if (take) begin
      rx_desc_addr <= slot_base(sel_core, slot_addr[sel_slot]) + ADDR_WIDTH'(RX_WRITE_OFFSET);
      rx_desc_len  <= pkt_len;
      rx_desc_tag  <= '{core: sel_core, slot: sel_slot};
    end
  end

endmodule

/* design/slot_tracker.sv */
module slot_tracker
  import pkt_sched_pkg::*;
(
  input  logic                  logic_clk,
  input  logic                  rst_n,
  input  logic [SLOT_COUNT-1:0] slot_valid,
  input  logic                  alloc_valid,
  input  core_id_t              alloc_core,
  input  slot_id_t              alloc_slot,
  input  logic                  release_valid,
  input  core_id_t              release_core,
  input  slot_id_t              release_slot,
  output logic [SLOT_TOTAL-1:0] avail_mask
);

  // bit core * SLOT_COUNT + slot
  logic [SLOT_TOTAL-1:0] busy;

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      if (alloc_valid) begin
        busy[alloc_core * SLOT_COUNT + alloc_slot] <= 1'b1;
      end
      if (release_valid) begin
        busy[release_core * SLOT_COUNT + release_slot] <= 1'b0;
      end
    end
  end

  // slot table is shared by all cores
  assign avail_mask = ~busy & {CORE_COUNT{slot_valid}};

endmodule

/* design/sync_fifo.sv */
module sync_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  ADDR_SIZE = 2
) (
  input  logic     logic_clk,
  input  logic     rst_n,
  input  payload_t wr_data,
  input  logic     wr_en,
  output logic     full,
  output payload_t rd_data,
  input  logic     rd_en,
  output logic     empty
);

  payload_t mem [2**ADDR_SIZE];

  // extra msb tells full from empty
  logic [ADDR_SIZE:0] wr_ptr;
  logic [ADDR_SIZE:0] rd_ptr;
  logic               do_wr;
  logic               do_rd;

  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[ADDR_SIZE] != rd_ptr[ADDR_SIZE]) &&
                 (wr_ptr[ADDR_SIZE-1:0] == rd_ptr[ADDR_SIZE-1:0]);

  // head word shown without a read
  assign rd_data = mem[rd_ptr[ADDR_SIZE-1:0]];

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge logic_clk) begin
    if (do_wr) begin
      mem[wr_ptr[ADDR_SIZE-1:0]] <= wr_data;
    end
  end

endmodule

/* design/tx_dispatch.sv */
module tx_dispatch
  import pkt_sched_pkg::*;
(
  input  logic                        logic_clk,
  input  logic                        rst_n,
  input  msg_t                        msg_data,
  input  core_id_t                    msg_core_no,
  input  logic                        msg_valid,
  output logic                        msg_ready,
  input  slot_addr_t [SLOT_COUNT-1:0] slot_addr,
  output addr_t                       tx_desc_addr,
  output len_t                        tx_desc_len,
  output tag_t                        tx_desc_tag,
  output logic                        tx_desc_valid,
  input  logic                        tx_desc_ready,
  output logic                        release_valid,
  output core_id_t                    release_core,
  output slot_id_t                    release_slot
);

  slot_id_t msg_slot;
  logic     accept;

  assign msg_slot  = msg_data[MSG_SLOT_LSB +: SLOT_BITS];
  assign msg_ready = !tx_desc_valid;
  assign accept    = msg_valid && msg_ready;

  always_ff @(posedge logic_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_desc_valid <= 1'b0;
    end else if (accept) begin
      tx_desc_valid <= 1'b1;
    end else if (tx_desc_ready) begin
      tx_desc_valid <= 1'b0;
    end
  end

  // transmit reads from the slot start, no rx offset
  always_ff @(posedge logic_clk) begin
    if (accept) begin
      tx_desc_addr <= slot_base(msg_core_no, slot_addr[msg_slot]);
      tx_desc_len  <= msg_data[MSG_LEN_LSB +: LEN_WIDTH];
      tx_desc_tag  <= '{core: msg_core_no, slot: msg_slot};
    end
  end

  // slot goes free once the descriptor is taken
  assign release_valid = tx_desc_valid && tx_desc_ready;
  assign release_core  = tx_desc_tag.core;
  assign release_slot  = tx_desc_tag.slot;

endmodule

/* verification/pkt_sched_props.sv */
module pkt_sched_props
  import pkt_sched_pkg::*;
(
  input logic  logic_clk,
  input logic  rst_n,
  input addr_t rx_desc_addr,
  input len_t  rx_desc_len,
  input tag_t  rx_desc_tag,
  input logic  rx_desc_valid,
  input logic  rx_desc_ready,
  input addr_t tx_desc_addr,
  input len_t  tx_desc_len,
  input tag_t  tx_desc_tag,
  input logic  tx_desc_valid,
  input logic  tx_desc_ready,
  input logic  s_axil_awvalid,
  input logic  s_axil_awready,
  input logic  s_axil_bvalid
);

  // number of failed assertions
  int fail_count = 0;

  // stalled receive descriptor keeps its fields
  rx_hold: assert property (@(posedge logic_clk) disable iff (!rst_n)
    rx_desc_valid && !rx_desc_ready |=>
    rx_desc_valid && $stable({rx_desc_addr, rx_desc_len, rx_desc_tag}))
    else begin
      $error("rx descriptor changed while stalled");
      fail_count++;
    end

  tx_hold: assert property (@(posedge logic_clk) disable iff (!rst_n)
    tx_desc_valid && !tx_desc_ready |=>
    tx_desc_valid && $stable({tx_desc_addr, tx_desc_len, tx_desc_tag}))
    else begin
      $error("tx descriptor changed while stalled");
      fail_count++;
    end

  // write response only after an accepted write
  b_after_aw: assert property (@(posedge logic_clk) disable iff (!rst_n)
    $rose(s_axil_bvalid) |-> $past(s_axil_awvalid && s_axil_awready))
    else begin
      $error("bvalid raised without a write acceptance");
      fail_count++;
    end

endmodule

bind pkt_sched_top pkt_sched_props u_props (.*);

/* verification/tb_pkt_sched.sv */
module tb_pkt_sched
  import pkt_sched_pkg::*;
();

  typedef enum int {OP_WR, OP_RD, OP_PKT, OP_MSG, OP_WAIT} op_e;
  // expected resp in bits 33 to 32 over the data, or {tx count, rx count} for waits
  typedef struct {
    op_e         op;
    logic [7:0]  addr;
    logic [63:0] data;
    logic [33:0] exp_val;
  } step_t;

  logic              logic_clk;
  logic              rst_n;
  logic [7:0]        s_axil_awaddr;
  logic              s_axil_awvalid;
  logic              s_axil_awready;
  logic [31:0]       s_axil_wdata;
  logic [3:0]        s_axil_wstrb;
  logic              s_axil_wvalid;
  logic              s_axil_wready;
  logic [1:0]        s_axil_bresp;
  logic              s_axil_bvalid;
  logic              s_axil_bready;
  logic [7:0]        s_axil_araddr;
  logic              s_axil_arvalid;
  logic              s_axil_arready;
  logic [31:0]       s_axil_rdata;
  logic [1:0]        s_axil_rresp;
  logic              s_axil_rvalid;
  logic              s_axil_rready;
  logic              incoming_pkt_valid;
  logic [15:0]       incoming_pkt_len;
  logic              incoming_pkt_ready;
  logic [17:0]       rx_desc_addr;
  logic [15:0]       rx_desc_len;
  logic [3:0]        rx_desc_tag;
  logic              rx_desc_valid;
  logic              rx_desc_ready;
  logic [3:0][63:0]  core_msg_data;
  logic [3:0]        core_msg_valid;
  logic [17:0]       tx_desc_addr;
  logic [15:0]       tx_desc_len;
  logic [3:0]        tx_desc_tag;
  logic              tx_desc_valid;
  logic              tx_desc_ready;

  step_t       steps [$];
  int          seed = 32'h6de4_574f;
  logic        stall_on;
  int          errors;
  int          checks;
  int          cycle_count;
  int          limit;

  // reference model state
  logic [15:0] m_busy;
  logic [3:0]  m_slot_valid;
  logic [6:0]  m_slot_addr [4];
  int          m_rx_rr;
  int          m_tx_rr;
  logic [15:0] pkt_q [$];
  logic [63:0] msg_mem [4][32];
  int          msg_wr [4];
  int          msg_rd [4];
  logic        rel_pend;
  int          rel_idx;
  int          tx_exp_idx;
  logic [3:0]  push_pend;
  logic [3:0][63:0] push_data;
  logic        rx_prev;
  logic        tx_prev;
  int          rx_count;
  int          tx_count;

  pkt_sched_top dut (.*);

  initial begin
    logic_clk = 1'b0;
    forever #10 logic_clk = ~logic_clk;
  end

  always @(posedge logic_clk) begin
    cycle_count <= cycle_count + 1;
    if (stall_on) begin
      rx_desc_ready <= ($random(seed) & 3) != 0;
      tx_desc_ready <= ($random(seed) & 3) != 0;
    end else begin
      rx_desc_ready <= 1'b1;
      tx_desc_ready <= 1'b1;
    end
  end

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  function automatic void add_step(op_e op, logic [7:0] a, logic [63:0] d, logic [33:0] e);
    step_t s;
    s.op = op;
    s.addr = a;
    s.data = d;
    s.exp_val = e;
    steps.push_back(s);
  endfunction

  function automatic logic [63:0] make_msg(int slot, logic [15:0] len);
    return {16'hc0de, len, 14'h0, slot[1:0], len};
  endfunction

  task automatic build_table();
    add_step(OP_RD, 8'h00, 0, {2'b00, 32'h0});
    add_step(OP_PKT, 0, 16'h40, 0);
    add_step(OP_PKT, 0, 16'h41, 0);
    add_step(OP_WAIT, 0, 20, 0);
    add_step(OP_WR, 8'h10, 32'h11, {2'b00, 32'h0});
    add_step(OP_WR, 8'h14, 32'h22, {2'b00, 32'h0});
    add_step(OP_WR, 8'h18, 32'h33, {2'b00, 32'h0});
    add_step(OP_WR, 8'h1c, 32'hff, {2'b00, 32'h0});
    // slots written but still disabled
    add_step(OP_WAIT, 0, 10, 0);
    add_step(OP_WR, 8'h00, 32'h1, {2'b00, 32'h0});
    add_step(OP_WAIT, 0, 10, {16'd0, 16'd2});
    add_step(OP_RD, 8'h10, 0, {2'b00, 32'h11});
    add_step(OP_RD, 8'h1c, 0, {2'b00, 32'h7f});
    add_step(OP_RD, 8'h00, 0, {2'b00, 32'h1});
    add_step(OP_RD, 8'h20, 0, {2'b10, 32'h0});
    add_step(OP_RD, 8'h04, 0, {2'b10, 32'h0});
    add_step(OP_WR, 8'h24, 32'h5, {2'b10, 32'h0});
    add_step(OP_WR, 8'h12, 32'h6, {2'b10, 32'h0});
    for (int i = 0; i < 14; i++) begin
      add_step(OP_PKT, 0, 16'h100 + i, 0);
    end
    // all 16 slots now busy so these two wait
    add_step(OP_PKT, 0, 16'h200, 0);
    add_step(OP_PKT, 0, 16'h201, 0);
    add_step(OP_WAIT, 0, 40, {16'd0, 16'd16});
    add_step(OP_MSG, 2, make_msg(1, 16'h300), 0);
    add_step(OP_WAIT, 0, 20, {16'd1, 16'd17});
    add_step(OP_MSG, 0, make_msg(3, 16'h301), 0);
    add_step(OP_MSG, 3, make_msg(0, 16'h302), 0);
    add_step(OP_MSG, 1, make_msg(2, 16'h303), 0);
    add_step(OP_MSG, 0, make_msg(0, 16'h304), 0);
    add_step(OP_WAIT, 0, 40, {16'd5, 16'd18});
    add_step(OP_MSG, 1, make_msg(1, 16'h305), 0);
    add_step(OP_MSG, 2, make_msg(2, 16'h306), 0);
    add_step(OP_MSG, 3, make_msg(3, 16'h307), 0);
    add_step(OP_MSG, 2, make_msg(0, 16'h308), 0);
    add_step(OP_MSG, 3, make_msg(1, 16'h309), 0);
    add_step(OP_MSG, 1, make_msg(3, 16'h30a), 0);
    add_step(OP_PKT, 0, 16'h202, 0);
    add_step(OP_PKT, 0, 16'h203, 0);
    add_step(OP_PKT, 0, 16'h204, 0);
    add_step(OP_WAIT, 0, 60, {16'd11, 16'd21});
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    @(posedge logic_clk);
    s_axil_awaddr  <= addr;
    s_axil_wdata   <= data;
    s_axil_awvalid <= 1'b1;
    s_axil_wvalid  <= 1'b1;
    @(negedge logic_clk);
    while (!s_axil_awready) @(negedge logic_clk);
    // address and data channels are taken together
    check_eq("wready", s_axil_wready, 1'b1);
    if (addr >= 8'h10 && addr < 8'h20 && addr[1:0] == 2'b00) begin
      m_slot_addr[(addr - 8'h10) >> 2] = data[6:0];
      m_slot_valid[(addr - 8'h10) >> 2] = 1'b1;
    end
    @(posedge logic_clk);
    s_axil_awvalid <= 1'b0;
    s_axil_wvalid  <= 1'b0;
    s_axil_bready  <= 1'b1;
    @(negedge logic_clk);
    while (!s_axil_bvalid) @(negedge logic_clk);
    check_eq("bresp", s_axil_bresp, exp_resp);
    @(posedge logic_clk);
    s_axil_bready <= 1'b0;
  endtask

  task automatic reg_read(input logic [7:0] addr, input logic [33:0] exp);
    @(posedge logic_clk);
    s_axil_araddr  <= addr;
    s_axil_arvalid <= 1'b1;
    @(negedge logic_clk);
    while (!s_axil_arready) @(negedge logic_clk);
    @(posedge logic_clk);
    s_axil_arvalid <= 1'b0;
    s_axil_rready  <= 1'b1;
    @(negedge logic_clk);
    while (!s_axil_rvalid) @(negedge logic_clk);
    check_eq("rresp", s_axil_rresp, exp[33:32]);
    check_eq("rdata", s_axil_rdata, exp[31:0]);
    @(posedge logic_clk);
    s_axil_rready <= 1'b0;
  endtask

  task automatic run_step(input step_t s);
    case (s.op)
      OP_WR: reg_write(s.addr, s.data[31:0], s.exp_val[33:32]);
      OP_RD: reg_read(s.addr, s.exp_val);
      OP_PKT: begin
        @(posedge logic_clk);
        incoming_pkt_valid <= 1'b1;
        incoming_pkt_len   <= s.data[15:0];
        @(negedge logic_clk);
        while (!incoming_pkt_ready) @(negedge logic_clk);
        @(posedge logic_clk);
        incoming_pkt_valid <= 1'b0;
      end
      OP_MSG: begin
        @(posedge logic_clk);
        core_msg_valid[s.addr[1:0]] <= 1'b1;
        core_msg_data[s.addr[1:0]]  <= s.data;
        @(posedge logic_clk);
        core_msg_valid <= '0;
      end
      default: begin
        stall_on <= 1'b0;
        repeat (s.data) @(posedge logic_clk);
        // counters only move on the falling edge
        check_eq("rx descriptor count", rx_count, s.exp_val[15:0]);
        check_eq("tx descriptor count", tx_count, s.exp_val[31:16]);
      end
    endcase
    stall_on <= 1'b1;
  endtask

  task automatic check_rx();
    int         core;
    int         slot;
    logic       found;
    logic [17:0] exp_addr;
    found = 1'b0;
    core = 0;
    slot = 0;
    for (int k = 0; k < 4; k++) begin
      for (int s = 0; s < 4; s++) begin
        if (!found && !m_busy[((m_rx_rr + k) % 4) * 4 + s] && m_slot_valid[s]) begin
          found = 1'b1;
          core = (m_rx_rr + k) % 4;
          slot = s;
        end
      end
    end
    assert (found && pkt_q.size() > 0) else begin
      errors++;
      $display("receive descriptor appeared with no free slot or no waiting packet");
    end
    if (found && pkt_q.size() > 0) begin
      exp_addr = {core[1:0], 1'b0, m_slot_addr[slot], 8'h00} + 18'h0a;
      check_eq("rx addr", rx_desc_addr, exp_addr);
      check_eq("rx len", rx_desc_len, pkt_q.pop_front());
      check_eq("rx tag", rx_desc_tag, {core[1:0], slot[1:0]});
      m_busy[core * 4 + slot] = 1'b1;
      m_rx_rr = (core + 1) % 4;
    end
  endtask

  task automatic check_tx();
    int          core;
    logic        found;
    logic [63:0] msg;
    found = 1'b0;
    core = 0;
    for (int k = 0; k < 4; k++) begin
      if (!found && msg_wr[(m_tx_rr + k) % 4] != msg_rd[(m_tx_rr + k) % 4]) begin
        found = 1'b1;
        core = (m_tx_rr + k) % 4;
      end
    end
    assert (found) else begin
      errors++;
      $display("transmit descriptor appeared with no message waiting");
    end
    if (found) begin
      msg = msg_mem[core][msg_rd[core] % 32];
      msg_rd[core]++;
      check_eq("tx addr", tx_desc_addr,
               {core[1:0], 1'b0, m_slot_addr[msg[17:16]], 8'h00});
      check_eq("tx len", tx_desc_len, msg[15:0]);
      check_eq("tx tag", tx_desc_tag, {core[1:0], msg[17:16]});
      tx_exp_idx = core * 4 + msg[17:16];
      m_tx_rr = (core + 1) % 4;
    end
  endtask

  // model follows the DUT one cycle behind its registered decisions
  always @(negedge logic_clk) begin
    if (rst_n) begin
      if (rx_desc_valid && !rx_prev) check_rx();
      if (tx_desc_valid && !tx_prev) check_tx();
      if (rel_pend) m_busy[rel_idx] = 1'b0;
      rel_pend = tx_desc_valid && tx_desc_ready;
      rel_idx = tx_exp_idx;
      for (int c = 0; c < 4; c++) begin
        if (push_pend[c]) begin
          msg_mem[c][msg_wr[c] % 32] = push_data[c];
          msg_wr[c]++;
        end
      end
      push_pend = core_msg_valid;
      push_data = core_msg_data;
      if (incoming_pkt_valid && incoming_pkt_ready) pkt_q.push_back(incoming_pkt_len);
      if (rx_desc_valid && rx_desc_ready) rx_count++;
      if (tx_desc_valid && tx_desc_ready) tx_count++;
      rx_prev = rx_desc_valid;
      tx_prev = tx_desc_valid;
    end
  end

  initial begin
    wait (limit > 0);
    while (cycle_count < limit) @(posedge logic_clk);
    $display("timeout: the run hung after %0d cycles", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    rst_n = 1'b0;
    {s_axil_awaddr, s_axil_awvalid, s_axil_wdata, s_axil_wvalid} = '0;
    s_axil_wstrb = 4'hf;
    {s_axil_bready, s_axil_araddr, s_axil_arvalid, s_axil_rready} = '0;
    {incoming_pkt_valid, incoming_pkt_len, core_msg_data, core_msg_valid} = '0;
    {rx_desc_ready, tx_desc_ready, stall_on} = '0;
    {errors, checks, cycle_count, rx_count, tx_count} = '0;
    {m_busy, m_slot_valid, m_rx_rr, m_tx_rr, rel_pend, rel_idx, tx_exp_idx} = '0;
    {push_pend, push_data, rx_prev, tx_prev} = '0;
    for (int c = 0; c < 4; c++) begin
      msg_wr[c] = 0;
      msg_rd[c] = 0;
      m_slot_addr[c] = '0;
    end
    limit = 0;
    build_table();
    limit = 40 * steps.size();
    repeat (3) @(posedge logic_clk);
    rst_n <= 1'b1;
    foreach (steps[i]) run_step(steps[i]);
    stall_on <= 1'b0;
    // nothing left behind in the model
    check_eq("packets left", pkt_q.size(), 0);
    for (int c = 0; c < 4; c++) begin
      check_eq("messages left", msg_wr[c] - msg_rd[c], 0);
    end
    errors += dut.u_props.fail_count;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule
